//--- design/risc5_pkg.sv
// --------------------------------------------------
// risc5 bus subsystem package
// address map, I/O slots, serial timing and FSM states
// --------------------------------------------------

package risc5_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------

  // byte address from the processor
  localparam int unsigned adr_w = 24;
  // data word on both directions
  localparam int unsigned data_w = 32;

  // --------------------------------------------------
  // memory map
  // --------------------------------------------------

  // 1 KiB of RAM, mirrored below the I/O page
  localparam int unsigned ram_words = 256;
  // word index width, taken from adr[9:2]
  localparam int unsigned ram_aw = $clog2(ram_words);

  // I/O page is the top 64 bytes
  // adr[23:6] all ones selects it
  localparam logic [adr_w-1:0] io_base = 24'hFFFFC0;

  // slot numbers from adr[5:2] inside the I/O page
  // slot 0 was the timer, not present here
  localparam logic [3:0] io_slot_bio        = 4'd1;
  localparam logic [3:0] io_slot_ser_data   = 4'd2;
  localparam logic [3:0] io_slot_ser_status = 4'd3;

  // --------------------------------------------------
  // serial port
  // --------------------------------------------------

  // clocks per bit, short for simulation
  localparam int unsigned baud_div = 8;
  // baud counter width
  localparam int unsigned baud_cnt_w = $clog2(baud_div);

  // shared by the receiver and the transmitter
  // start and stop each last one bit time
  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } ser_state_t;

endpackage

//--- design/cpu_bus_if.sv
// --------------------------------------------------
// processor bus bundle
// address, strobes, byte enable and both data paths
// --------------------------------------------------

interface cpu_bus_if import risc5_pkg::*; ();

  // byte address
  logic [adr_w-1:0]  adr;
  // read and write strobes, never both high
  logic              rd;
  logic              wr;
  // byte access when high, RAM only
  logic              ben;
  // data from the processor
  logic [data_w-1:0] wdata;
  // data to the processor, combinational
  logic [data_w-1:0] rdata;

  // processor side
  modport master (
    output adr,
    output rd,
    output wr,
    output ben,
    output wdata,
    input  rdata
  );

  // decoder and target side
  modport slave (
    input  adr,
    input  rd,
    input  wr,
    input  ben,
    input  wdata,
    output rdata
  );

endinterface

//--- design/io_decoder.sv
// --------------------------------------------------
// address decoder and read data multiplexer
// splits RAM from the I/O page, one select per target
// --------------------------------------------------

module io_decoder import risc5_pkg::*; (
  cpu_bus_if.slave    bus,
  output logic        ram_sel,
  output logic        bio_sel,
  output logic        ser_data_sel,
  output logic        ser_status_sel,
  input  [data_w-1:0] ram_rdata,
  input  [data_w-1:0] bio_rdata,
  input  [data_w-1:0] ser_rdata
);

  // I/O page hit
  logic       io_en;
  // slot inside the page
  logic [3:0] io_slot;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------

  // top 18 address bits all ones
  assign io_en   = (bus.adr[adr_w-1:6] == io_base[adr_w-1:6]);
  assign io_slot = bus.adr[5:2];

  // everything below the I/O page is RAM
  // RAM itself ignores bits above 9, hence the mirror
  assign ram_sel = ~io_en;

  assign bio_sel        = io_en & (io_slot == io_slot_bio);
  assign ser_data_sel   = io_en & (io_slot == io_slot_ser_data);
  assign ser_status_sel = io_en & (io_slot == io_slot_ser_status);

  // --------------------------------------------------
  // read data
  // --------------------------------------------------

  always_comb begin
    if (ram_sel) begin
      bus.rdata = ram_rdata;
    end else if (bio_sel) begin
      bus.rdata = bio_rdata;
    end else if (ser_data_sel || ser_status_sel) begin
      // serial block muxes data and status itself
      bus.rdata = ser_rdata;
    end else begin
      // unmapped slot reads zero
      bus.rdata = '0;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // targets never share a cycle on the bus
  // evaluated on every address change
  a_one_select: assert property (
    @(bus.adr)
    $onehot0({ram_sel, bio_sel, ser_data_sel, ser_status_sel})
  );

endmodule

//--- design/ram.sv
// --------------------------------------------------
// word RAM with byte access
// byte writes, zero-extended byte reads, async read
// --------------------------------------------------

module ram import risc5_pkg::*; (
  input                     clk,
  input                     sel,
  cpu_bus_if.slave          bus,
  output logic [data_w-1:0] rdata
);

  // storage
  logic [data_w-1:0] mem [ram_words];

  // word index from adr[9:2], upper bits mirror
  logic [ram_aw-1:0] word_idx;
  // byte lane from adr[1:0]
  logic [1:0]        lane;
  // addressed word, read without a clock
  logic [data_w-1:0] word_q;
  // addressed byte out of that word
  logic [7:0]        byte_q;

  assign word_idx = bus.adr[ram_aw+1:2];
  assign lane     = bus.adr[1:0];

  // --------------------------------------------------
  // write port
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (sel && bus.wr) begin
      if (bus.ben) begin
        // only the addressed lane, from the low byte
        mem[word_idx][8*lane +: 8] <= bus.wdata[7:0];
      end else begin
        mem[word_idx] <= bus.wdata;
      end
    end
  end

  // --------------------------------------------------
  // read port
  // --------------------------------------------------

  assign word_q = mem[word_idx];
  assign byte_q = word_q[8*lane +: 8];

  always_comb begin
    if (bus.ben) begin
      // byte read is zero-extended
      rdata = {{(data_w-8){1'b0}}, byte_q};
    end else begin
      rdata = word_q;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // the master never reads and writes in one cycle
  // a write would otherwise race the async read
  a_no_rd_wr: assert property (
    @(posedge clk)
    !(bus.rd && bus.wr)
  );

endmodule

//--- design/bio.sv
// --------------------------------------------------
// board I/O
// LED register out and synchronised switch inputs
// --------------------------------------------------

module bio import risc5_pkg::*; (
  input                     clk,
  input                     arst_n,
  input                     sel,
  input                     wr,
  input        [7:0]        wdata,
  input        [7:0]        swi,
  output logic [7:0]        leds,
  output logic [data_w-1:0] rdata
);

  // two stage switch synchroniser
  logic [7:0] swi_meta;
  logic [7:0] swi_sync;
  // LED register
  logic [7:0] led_q;

  // --------------------------------------------------
  // switch sampling
  // --------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      swi_meta <= '0;
      swi_sync <= '0;
    end else begin
      swi_meta <= swi;
      swi_sync <= swi_meta;
    end
  end

  // --------------------------------------------------
  // LED register
  // --------------------------------------------------

  // full word access, low byte only kept
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      led_q <= '0;
    end else if (sel && wr) begin
      led_q <= wdata;
    end
  end

  assign leds = led_q;

  // switches low, LEDs read back above them
  assign rdata = {{(data_w-16){1'b0}}, led_q, swi_sync};

endmodule

//--- design/ser.sv
// --------------------------------------------------
// serial port, 8N1
// UART transmitter and receiver with data and status
// --------------------------------------------------

module ser import risc5_pkg::*; (
  input                     clk,
  input                     arst_n,
  input                     data_sel,
  input                     status_sel,
  input                     rd,
  input                     wr,
  input        [7:0]        wdata,
  input                     rxd,
  output logic              txd,
  output logic [data_w-1:0] rdata
);

  // transmitter
  ser_state_t            tx_state;
  logic [baud_cnt_w-1:0] tx_cnt;
  logic [2:0]            tx_bit;
  logic [7:0]            tx_shift;
  logic                  tx_end;
  logic                  tx_go;
  logic                  tx_ready;
  // receiver
  ser_state_t            rx_state;
  logic [baud_cnt_w-1:0] rx_cnt;
  logic [2:0]            rx_bit;
  logic [7:0]            rx_shift;
  logic [7:0]            rx_data;
  logic                  rx_ready;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic                  rx_done;

  // --------------------------------------------------
  // transmitter
  // --------------------------------------------------

  assign tx_ready = (tx_state == st_idle);
  // writes while busy are dropped
  assign tx_go  = data_sel & wr & tx_ready;
  assign tx_end = (tx_cnt == baud_cnt_w'(baud_div - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_state <= st_idle;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      txd      <= 1'b1;
    end else begin
      tx_cnt <= tx_end ? '0 : tx_cnt + 1'b1;
      case (tx_state)
        st_idle: begin
          tx_cnt <= '0;
          if (tx_go) begin
            tx_state <= st_start;
            txd      <= 1'b0;
          end
        end
        st_start: if (tx_end) begin
          tx_state <= st_data;
          tx_bit   <= '0;
          txd      <= tx_shift[0];
        end
        st_data: if (tx_end) begin
          // lsb first, next bit sits at [1] before the shift
          if (tx_bit == 3'd7) begin
            tx_state <= st_stop;
            txd      <= 1'b1;
          end else begin
            tx_bit <= tx_bit + 1'b1;
            txd    <= tx_shift[1];
          end
        end
        st_stop: if (tx_end) begin
          // ready again from here
          tx_state <= st_idle;
        end
        default: tx_state <= st_idle;
      endcase
    end
  end

  // payload shifter
  always_ff @(posedge clk) begin
    if (tx_go) begin
      tx_shift <= wdata;
    end else if (tx_state == st_data && tx_end) begin
      tx_shift <= tx_shift >> 1;
    end
  end

  // --------------------------------------------------
  // receiver
  // --------------------------------------------------

  // line idles high
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rxd;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // middle of the stop bit ends the frame
  assign rx_done = (rx_state == st_stop) && (rx_cnt == baud_cnt_w'(baud_div - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_state <= st_idle;
      rx_cnt   <= '0;
      rx_bit   <= '0;
    end else begin
      rx_cnt <= rx_cnt + 1'b1;
      case (rx_state)
        st_idle: begin
          rx_cnt <= '0;
          // falling edge starts a frame
          if (rx_prev && !rx_sync) begin
            rx_state <= st_start;
          end
        end
        st_start: if (rx_cnt == baud_cnt_w'(baud_div / 2 - 1)) begin
          // half a bit in, glitch returns to idle
          rx_cnt   <= '0;
          rx_bit   <= '0;
          rx_state <= rx_sync ? st_idle : st_data;
        end
        st_data: if (rx_cnt == baud_cnt_w'(baud_div - 1)) begin
          rx_cnt <= '0;
          rx_bit <= rx_bit + 1'b1;
          if (rx_bit == 3'd7) begin
            rx_state <= st_stop;
          end
        end
        st_stop: if (rx_done) begin
          rx_state <= st_idle;
        end
        default: rx_state <= st_idle;
      endcase
    end
  end

  // sampled bits and held byte
  always_ff @(posedge clk) begin
    if (rx_state == st_data && rx_cnt == baud_cnt_w'(baud_div - 1)) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
    // a new byte overwrites the old one
    if (rx_done) begin
      rx_data <= rx_shift;
    end
  end

  // set wins over a clearing read on the same edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_ready <= 1'b0;
    end else if (rx_done) begin
      rx_ready <= 1'b1;
    end else if (data_sel && rd) begin
      rx_ready <= 1'b0;
    end
  end

  // --------------------------------------------------
  // read data
  // --------------------------------------------------

  always_comb begin
    if (data_sel) begin
      rdata = {{(data_w-8){1'b0}}, rx_data};
    end else if (status_sel) begin
      // bit 1 tx_ready, bit 0 rx_ready
      rdata = {{(data_w-2){1'b0}}, tx_ready, rx_ready};
    end else begin
      rdata = '0;
    end
  end

  // idle transmitter holds the line in mark state
  a_txd_idle: assert property (
    @(posedge clk) disable iff (!arst_n)
    (tx_state == st_idle) |-> txd
  );

endmodule

//--- design/risc5_io.sv
// --------------------------------------------------
// risc5 bus subsystem top level
// RAM, board I/O and serial port behind one decoder
// --------------------------------------------------

module risc5_io import risc5_pkg::*; (
  input                     clk,
  input                     arst_n,
  // processor bus
  input        [adr_w-1:0]  adr,
  input                     rd,
  input                     wr,
  input                     ben,
  input        [data_w-1:0] wdata,
  output logic [data_w-1:0] rdata,
  // board
  output logic [7:0]        leds,
  input        [7:0]        swi,
  // serial line
  output logic              txd,
  input                     rxd
);

  // target selects
  logic ram_sel;
  logic bio_sel;
  logic ser_data_sel;
  logic ser_status_sel;
  // target read words
  logic [data_w-1:0] ram_rdata;
  logic [data_w-1:0] bio_rdata;
  logic [data_w-1:0] ser_rdata;

  // --------------------------------------------------
  // bus bundle
  // --------------------------------------------------

  cpu_bus_if bus ();

  assign bus.adr   = adr;
  assign bus.rd    = rd;
  assign bus.wr    = wr;
  assign bus.ben   = ben;
  assign bus.wdata = wdata;
  assign rdata     = bus.rdata;

  // --------------------------------------------------
  // instances
  // --------------------------------------------------

  io_decoder io_decoder_i (
    .bus            (bus),
    .ram_sel        (ram_sel),
    .bio_sel        (bio_sel),
    .ser_data_sel   (ser_data_sel),
    .ser_status_sel (ser_status_sel),
    .ram_rdata      (ram_rdata),
    .bio_rdata      (bio_rdata),
    .ser_rdata      (ser_rdata)
  );

  ram ram_i (
    .clk   (clk),
    .sel   (ram_sel),
    .bus   (bus),
    .rdata (ram_rdata)
  );

  // I/O takes full words, low byte only
  bio bio_i (
    .clk    (clk),
    .arst_n (arst_n),
    .sel    (bio_sel),
    .wr     (wr),
    .wdata  (wdata[7:0]),
    .swi    (swi),
    .leds   (leds),
    .rdata  (bio_rdata)
  );

  ser ser_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .data_sel   (ser_data_sel),
    .status_sel (ser_status_sel),
    .rd         (rd),
    .wr         (wr),
    .wdata      (wdata[7:0]),
    .rxd        (rxd),
    .txd        (txd),
    .rdata      (ser_rdata)
  );

endmodule

//--- tests/tb_risc5_io.sv
// --------------------------------------------------
// testbench for the risc5 bus subsystem
// replays bus operations from a data file, serial looped back
// --------------------------------------------------

module tb_risc5_io import risc5_pkg::*; ();

  localparam string data_path = "tests/risc5_io_tests.txt";
  // bound on data file length
  localparam int max_ops = 1000;

  logic              clk;
  logic              arst_n;
  logic [adr_w-1:0]  adr;
  logic              rd;
  logic              wr;
  logic              ben;
  logic [data_w-1:0] wdata;
  logic [data_w-1:0] rdata;
  logic [7:0]        leds;
  logic [7:0]        swi;
  // txd feeds rxd directly
  logic              serial_line;

  // LED register as written so far, zero from reset
  logic [7:0]        led_exp;

  // error and test counts
  int errs_in_test;
  int total_errs;
  int tests_ok;
  int tests_bad;

  always #4 clk = ~clk;

  risc5_io dut_i (
    .clk    (clk),
    .arst_n (arst_n),
    .adr    (adr),
    .rd     (rd),
    .wr     (wr),
    .ben    (ben),
    .wdata  (wdata),
    .rdata  (rdata),
    .leds   (leds),
    .swi    (swi),
    .txd    (serial_line),
    .rxd    (serial_line)
  );

  // --------------------------------------------------
  // bus cycles, entered 1 unit after a rising edge
  // --------------------------------------------------

  task automatic drive_idle();
    adr   = '0;
    rd    = 1'b0;
    wr    = 1'b0;
    ben   = 1'b0;
    wdata = '0;
  endtask

  // write lands on the next edge
  task automatic bus_write(input logic [adr_w-1:0] a, input logic [data_w-1:0] d,
                           input logic b);
    adr   = a;
    wr    = 1'b1;
    ben   = b;
    wdata = d;
    @(posedge clk);
    #1;
    drive_idle();
  endtask

  // rdata taken 1 unit before the edge
  task automatic bus_read(input logic [adr_w-1:0] a, input logic b,
                          output logic [data_w-1:0] d);
    adr = a;
    rd  = 1'b1;
    ben = b;
    #6;
    d = rdata;
    @(posedge clk);
    #1;
    drive_idle();
  endtask

  task automatic check_read(input logic [adr_w-1:0] a, input logic [data_w-1:0] exp,
                            input logic b);
    logic [data_w-1:0] got;
    bus_read(a, b, got);
    assert (got === exp) else begin
      $display("Mismatch at %0t: adr %h expected %h got %h", $time, a, exp, got);
      errs_in_test++;
    end
  endtask

  // board I/O slot 1 in the top page takes the low byte
  task automatic check_leds(input logic [adr_w-1:0] a, input logic [data_w-1:0] d);
    if ((&a[adr_w-1:6]) && (a[5:2] == io_slot_bio)) begin
      led_exp = d[7:0];
    end
    assert (leds === led_exp) else begin
      $display("Mismatch at %0t: leds after write to %h expected %h got %h",
               $time, a, led_exp, leds);
      errs_in_test++;
    end
  endtask

  // one read per cycle until the masked word matches
  task automatic poll_until(input logic [adr_w-1:0] a, input logic [data_w-1:0] mask,
                            input logic [data_w-1:0] exp, input int limit);
    logic [data_w-1:0] got;
    int                cycles;
    logic              hit;
    cycles = 0;
    hit    = 1'b0;
    while (!hit && cycles < limit) begin
      bus_read(a, 1'b0, got);
      hit = ((got & mask) == exp);
      cycles++;
    end
    assert (hit) else begin
      $display("status bits %h at %h never reached %h within %0d cycles",
               mask, a, exp, limit);
      errs_in_test++;
    end
  endtask

  // the masked word must not match for the whole window
  task automatic stay_clear(input logic [adr_w-1:0] a, input logic [data_w-1:0] mask,
                            input logic [data_w-1:0] value, input int limit);
    logic [data_w-1:0] got;
    int                cycles;
    logic              hit;
    cycles = 0;
    hit    = 1'b0;
    while (!hit && cycles < limit) begin
      bus_read(a, 1'b0, got);
      hit = ((got & mask) == value);
      cycles++;
    end
    assert (!hit) else begin
      $display("status bits %h at %h reached %h after %0d cycles, no byte was expected",
               mask, a, value, cycles);
      errs_in_test++;
    end
  endtask

  task automatic check_fields(input int n, input int k);
    assert (n == k) else begin
      $display("malformed line in data file, %0d of %0d fields read", n, k);
      errs_in_test++;
    end
  endtask

  // one line per finished test
  task automatic close_test(input logic [8*32-1:0] name);
    if (errs_in_test == 0) begin
      tests_ok++;
      $display("[ok]   %0s", name);
    end else begin
      tests_bad++;
      $display("[fail] %0s with %0d errors", name, errs_in_test);
    end
    total_errs  += errs_in_test;
    errs_in_test = 0;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    int                fd;
    int                n;
    int                op_count;
    int                f_lim;
    logic              eof;
    logic [7:0]        op;
    logic [31:0]       f_a;
    logic [31:0]       f_d;
    logic [31:0]       f_b;
    logic [31:0]       f_m;
    logic [8*32-1:0]   name;
    logic [8*128-1:0]  rest;
    clk          = 1'b0;
    arst_n       = 1'b0;
    swi          = '0;
    led_exp      = '0;
    errs_in_test = 0;
    total_errs   = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    drive_idle();
    fd = $fopen(data_path, "r");
    if (fd == 0) begin
      $display("could not open %0s", data_path);
      $display("test failed");
      $finish;
    end else begin
      // 4 cycles in reset
      repeat (4) @(posedge clk);
      #1;
      arst_n   = 1'b1;
      eof      = 1'b0;
      op_count = 0;
      while (!eof && op_count < max_ops) begin
        n = $fscanf(fd, "%s", op);
        if (n != 1) begin
          eof = 1'b1;
        end else begin
          op_count++;
          case (op)
            "#": n = $fgets(rest, fd);
            "W": begin
              n = $fscanf(fd, "%h %h %h", f_a, f_d, f_b);
              check_fields(n, 3);
              bus_write(f_a[adr_w-1:0], f_d, f_b[0]);
              check_leds(f_a[adr_w-1:0], f_d);
            end
            "R": begin
              n = $fscanf(fd, "%h %h %h", f_a, f_d, f_b);
              check_fields(n, 3);
              check_read(f_a[adr_w-1:0], f_d, f_b[0]);
            end
            "P": begin
              n = $fscanf(fd, "%h %h %h %d", f_a, f_m, f_d, f_lim);
              check_fields(n, 4);
              poll_until(f_a[adr_w-1:0], f_m, f_d, f_lim);
            end
            "N": begin
              n = $fscanf(fd, "%h %h %h %d", f_a, f_m, f_d, f_lim);
              check_fields(n, 4);
              stay_clear(f_a[adr_w-1:0], f_m, f_d, f_lim);
            end
            "S": begin
              n = $fscanf(fd, "%h", f_d);
              check_fields(n, 1);
              swi = f_d[7:0];
            end
            "T": begin
              n = $fscanf(fd, "%s", name);
              check_fields(n, 1);
              close_test(name);
            end
            default: begin
              $display("unknown operation %s in data file", op);
              errs_in_test++;
            end
          endcase
        end
      end
      if (!eof) begin
        $display("data file holds more than %0d operations", max_ops);
        errs_in_test++;
      end
      $fclose(fd);
      // errors after the last marker
      total_errs += errs_in_test;
      $display("summary: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, total_errs);
      if (total_errs == 0 && tests_bad == 0 && tests_ok > 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

//--- tests/risc5_io_tests.txt
# W adr data ben | R adr expected ben | P adr mask value limit | S switches | T name
# N adr mask value limit checks that the masked value does not appear
# ram word and byte access
W 000010 11223344 0
W 000014 AABBCCDD 0
R 000010 11223344 0
R 000014 AABBCCDD 0
W 000011 0000005A 1
W 000016 000000EE 1
R 000011 0000005A 1
R 000010 00000044 1
R 000013 00000011 1
R 000016 000000EE 1
R 000010 11225A44 0
R 000014 AAEECCDD 0
T ram_access
# ram mirroring above bit 9
W 00F3F0 CAFEF00D 0
R 0003F0 CAFEF00D 0
R 000410 11225A44 0
R 7FFC14 AAEECCDD 0
T ram_mirror
# board io, leds in 15..8 and switches in 7..0
W FFFFC4 000000A6 0
R FFFFC4 0000A600 0
S 3C
P FFFFC4 000000FF 0000003C 8
R FFFFC4 0000A63C 0
T board_io
# unmapped slots 0 and 4 to 15
R FFFFC0 00000000 0
R FFFFD0 00000000 0
R FFFFD4 00000000 0
R FFFFD8 00000000 0
R FFFFDC 00000000 0
R FFFFE0 00000000 0
R FFFFE4 00000000 0
R FFFFE8 00000000 0
R FFFFEC 00000000 0
R FFFFF0 00000000 0
R FFFFF4 00000000 0
R FFFFF8 00000000 0
R FFFFFC 00000000 0
T unmapped
# serial loopback
W FFFFC8 0000005A 0
P FFFFCC 00000001 00000001 96
R FFFFC8 0000005A 0
R FFFFCC 00000002 0
T serial_loop
# second write while busy is dropped
W FFFFC8 000000A5 0
W FFFFC8 0000003C 0
P FFFFCC 00000001 00000001 96
R FFFFC8 000000A5 0
R FFFFCC 00000002 0
N FFFFCC 00000001 00000001 96
T serial_busy

//--- all.f
design/risc5_pkg.sv
design/cpu_bus_if.sv
design/io_decoder.sv
design/ram.sv
design/bio.sv
design/ser.sv
design/risc5_io.sv
tests/tb_risc5_io.sv

//--- Makefile
# Verilator simulation of the risc5 bus subsystem

VERILATOR ?= verilator
TOP       ?= tb_risc5_io
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --assert

.PHONY: sim clean

# build, run from the project root, then search the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
